// ==== include/mvu_params.svh ====
// MVU kernel sizing: array dimensions, operand widths, DSP chain segmentation and latency
`ifndef MVU_PARAMS_SVH
`define MVU_PARAMS_SVH

// array dimensions
`define MVU_PE 2 // output lanes, one DSP chain each
`define MVU_SIMD 8 // elements per dot product

// operand and result widths
`define MVU_WGT_W 8 // signed weight bits
`define MVU_ACT_W 8 // unsigned activation bits
`define MVU_ACCU_W 24 // lane result bits, truncated from the cascade

// chain geometry
`define MVU_LANES 3 // multiplier lanes packed into one slice
`define MVU_CHAIN_LEN ((`MVU_SIMD + `MVU_LANES - 1) / `MVU_LANES) // slices per chain
`define MVU_SEG_LEN 2 // slices sharing one input delay
`define MVU_SEGMENTS ((`MVU_CHAIN_LEN + `MVU_SEG_LEN - 1) / `MVU_SEG_LEN)
`define MVU_CASC_W 58 // partial-sum cascade width

// enabled cycles from a last beat to vld
`define MVU_LATENCY (`MVU_SEGMENTS + 2)

`endif

// ==== src/mvu_pkg.sv ====
// shared operand, cascade and result types plus slice-placement helpers for the MVU kernel
`default_nettype none

`include "mvu_params.svh"

package mvu_pkg;

	typedef logic [8:0] actLane_t; // dsp A lane, activation zero-extended to 9 bits
	typedef logic signed [7:0] wgtLane_t; // dsp B lane, weight sign-extended to 8 bits

	typedef actLane_t [`MVU_LANES-1:0] actSlice_t; // unused lanes held at zero
	typedef wgtLane_t [`MVU_LANES-1:0] wgtSlice_t;

	typedef logic signed [`MVU_CASC_W-1:0] casc_t; // partial sum between slices
	typedef logic signed [`MVU_ACCU_W-1:0] accu_t; // per-lane result

	typedef logic [`MVU_SIMD-1:0][`MVU_ACT_W-1:0] actVec_t; // raw activations, shared by all lanes
	typedef logic [`MVU_PE-1:0][`MVU_SIMD-1:0][`MVU_WGT_W-1:0] wgtMat_t; // raw weights per lane
	typedef accu_t [`MVU_PE-1:0] accuVec_t;

	typedef logic [`MVU_SEGMENTS-1:0] segFlags_t; // one bit per segment

	typedef struct packed {
		logic last; // closes the dot product
		logic zero; // beat contributes nothing
	} beat_t;

	// segment a slice sits in
	function automatic int unsigned sliceSeg(input int unsigned idx);
		return idx / `MVU_SEG_LEN;
	endfunction

	// external delay ahead of a slice; the second segment uses the dsp's own second input reg
	function automatic int unsigned skewDepth(input int unsigned idx);
		return (sliceSeg(idx) > 1) ? sliceSeg(idx) - 1 : 0;
	endfunction

	// occupied lanes, only the tail slice can be partial
	function automatic int unsigned sliceLanes(input int unsigned idx);
		return (idx == `MVU_CHAIN_LEN - 1) ? `MVU_SIMD - `MVU_LANES * idx : `MVU_LANES;
	endfunction

endpackage

`default_nettype wire

// ==== src/operand_skew.sv ====
// enable-gated delay line that lines an operand up with the partial-sum cascade
`timescale 1ns/1ps
`default_nettype none

module operand_skew #(
	parameter type payload_t = logic, // operand carried through the line
	parameter int unsigned Depth = 1 // enabled cycles of delay
) (
	input logic clk,
	input logic rst,
	input logic en_i, // advance, otherwise hold
	input payload_t d_i,
	output payload_t q_o
);

	if (Depth == 0) begin : genPass
		assign q_o = d_i; // early segments need no extra delay
	end else begin : genShift
		payload_t stages [Depth]; // stages[0] is the newest entry

		always_ff @(posedge clk) begin
			if (rst) begin
				for (int k = 0; k < Depth; k++) begin
					stages[k] <= '0;
				end
			end else if (en_i) begin
				stages[0] <= d_i;
				for (int k = 1; k < Depth; k++) begin
					stages[k] <= stages[k - 1]; // shift toward the tail
				end
			end
		end

		assign q_o = stages[Depth - 1]; // oldest entry
	end

endmodule

`default_nettype wire

// ==== src/mvu_control.sv ====
// MVU control pipeline: last/valid shift register and per-segment zero flags
`timescale 1ns/1ps
`default_nettype none

`include "mvu_params.svh"

module mvu_control (
	input logic clk,
	input logic rst,
	input logic en_i, // pipeline advance
	input mvu_pkg::beat_t beat_i, // controls of the incoming beat
	output mvu_pkg::segFlags_t zeroSeg_o, // bit s = zero flag delayed s enabled cycles
	output logic clearAcc_o, // last flag one step before vld
	output logic vld_o // lane results valid
);

	import mvu_pkg::*;

	// last flag enters at the msb and drains toward bit 0
	logic [`MVU_LATENCY-1:0] lastPipe;
	segFlags_t zeroHist; // zeroSeg_o delayed by one enabled cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0; // no result in flight
		end else if (en_i) begin
			lastPipe <= {beat_i.last, lastPipe[`MVU_LATENCY-1:1]};
		end
	end

	assign clearAcc_o = lastPipe[1]; // registered again inside the final slice
	assign vld_o = lastPipe[0]; // tail of the pipe

	// one-deep skew on the whole flag vector, fed back shifted by one segment
	operand_skew #(
		.payload_t(segFlags_t),
		.Depth(1)
	) u_zeroSkew (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.d_i(zeroSeg_o),
		.q_o(zeroHist)
	);

	always_comb begin
		zeroSeg_o[0] = beat_i.zero; // first segment sees the beat directly
		for (int s = 1; s < `MVU_SEGMENTS; s++) begin
			zeroSeg_o[s] = zeroHist[s - 1]; // each segment one enabled cycle behind the previous
		end
	end

endmodule

`default_nettype wire

// ==== src/dot_slice.sv ====
// behavioral DSP slice: three-lane 9x8 signed multiply, cascade add and optional accumulate
`timescale 1ns/1ps
`default_nettype none

`include "mvu_params.svh"

module dot_slice #(
	parameter int unsigned Index = 0 // position in the chain
) (
	input logic clk,
	input logic rst,
	input logic en_i, // clock enable for every stage
	input mvu_pkg::actSlice_t act_i, // packed activations, already skewed
	input mvu_pkg::wgtSlice_t wgt_i, // packed weights, already skewed
	input logic zero_i, // zero flag of this segment
	input logic clearAcc_i, // restart accumulation, used by the tail slice
	input mvu_pkg::casc_t cascIn_i, // partial sum from the predecessor
	output mvu_pkg::casc_t cascOut_o // partial sum to the successor
);

	import mvu_pkg::*;

	localparam int unsigned Seg = sliceSeg(Index);
	localparam int unsigned InRegs = (Seg > 0) ? 2 : 1; // a/b register depth
	localparam bit IsFirst = (Index == 0);
	localparam bit IsLast = (Index == `MVU_CHAIN_LEN - 1);
	localparam bit HasPReg = ((Index + 1) % `MVU_SEG_LEN == 0) || IsLast; // segment boundary

	actSlice_t actReg [InRegs]; // A register stages
	wgtSlice_t wgtReg [InRegs]; // B register stages
	logic zeroReg; // inmode zero, aligned with the last a/b stage
	casc_t prodSum; // sum of the three lane products
	casc_t mReg; // multiplier register
	casc_t cascTerm; // cascade contribution, none on the head slice

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < InRegs; k++) begin
				actReg[k] <= '0;
				wgtReg[k] <= '0;
			end
			zeroReg <= 1'b0;
		end else if (en_i) begin
			actReg[0] <= act_i;
			wgtReg[0] <= wgt_i;
			for (int k = 1; k < InRegs; k++) begin
				actReg[k] <= actReg[k - 1]; // second stage beyond the first segment
				wgtReg[k] <= wgtReg[k - 1];
			end
			zeroReg <= zero_i;
		end
	end

	always_comb begin
		logic signed [16:0] prod; // one 9x8 lane product
		prodSum = '0;
		for (int k = 0; k < `MVU_LANES; k++) begin
			prod = $signed(actReg[InRegs - 1][k]) * $signed(wgtReg[InRegs - 1][k]); // act msb is 0
			prodSum = prodSum + prod; // sign-extended to cascade width
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mReg <= '0;
		end else if (en_i) begin
			mReg <= zeroReg ? '0 : prodSum; // zero beat drops its products
		end
	end

	assign cascTerm = IsFirst ? '0 : cascIn_i;

	if (IsLast) begin : genAccu
		logic clearReg; // opmode register, selects 0 instead of P feedback
		casc_t pReg;

		always_ff @(posedge clk) begin
			if (rst) begin
				clearReg <= 1'b0;
				pReg <= '0; // accumulator starts empty
			end else if (en_i) begin
				clearReg <= clearAcc_i;
				pReg <= (clearReg ? '0 : pReg) + mReg + cascTerm;
			end
		end

		assign cascOut_o = pReg; // lane result
	end else if (HasPReg) begin : genPReg
		casc_t pReg; // breaks the cascade at the segment end

		always_ff @(posedge clk) begin
			if (rst) begin
				pReg <= '0;
			end else if (en_i) begin
				pReg <= mReg + cascTerm;
			end
		end

		assign cascOut_o = pReg;
	end else begin : genComb
		assign cascOut_o = mReg + cascTerm; // P unregistered inside a segment
	end

endmodule

`default_nettype wire

// ==== src/pe_chain.sv ====
// one MVU output lane: weight packing and skew feeding a cascaded chain of DSP slices
`timescale 1ns/1ps
`default_nettype none

`include "mvu_params.svh"

module pe_chain (
	input logic clk,
	input logic rst,
	input logic en_i, // pipeline advance
	input mvu_pkg::actSlice_t actSlices_i [`MVU_CHAIN_LEN], // shared activations, skewed
	input logic [`MVU_SIMD-1:0][`MVU_WGT_W-1:0] wgt_i, // this lane's raw weights
	input mvu_pkg::segFlags_t zeroSeg_i, // zero flag per segment
	input logic clearAcc_i, // restart accumulation in the tail slice
	output mvu_pkg::accu_t p_o // lane result
);

	import mvu_pkg::*;

	casc_t casc [`MVU_CHAIN_LEN]; // cascade out of each slice

	for (genvar j = 0; j < `MVU_CHAIN_LEN; j++) begin : genSlice
		localparam int unsigned Lanes = sliceLanes(j); // occupied lanes
		localparam int unsigned Seg = sliceSeg(j);

		wgtSlice_t wgtIn; // packed, sign-extended
		wgtSlice_t wgtSkewed; // delayed for the segment
		casc_t cascIn;

		always_comb begin
			wgtIn = '0; // spare lanes of the tail slice stay zero
			for (int k = 0; k < Lanes; k++) begin
				wgtIn[k] = wgtLane_t'($signed(wgt_i[`MVU_LANES * j + k]));
			end
		end

		operand_skew #(
			.payload_t(wgtSlice_t),
			.Depth(skewDepth(j))
		) u_wgtSkew (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.d_i(wgtIn),
			.q_o(wgtSkewed)
		);

		if (j == 0) begin : genHead
			assign cascIn = '0; // nothing upstream of the head
		end else begin : genLink
			assign cascIn = casc[j - 1];
		end

		dot_slice #(
			.Index(j)
		) u_slice (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.act_i(actSlices_i[j]),
			.wgt_i(wgtSkewed),
			.zero_i(zeroSeg_i[Seg]), // delay matches this segment's operands
			.clearAcc_i(clearAcc_i),
			.cascIn_i(cascIn),
			.cascOut_o(casc[j])
		);
	end

	assign p_o = casc[`MVU_CHAIN_LEN - 1][`MVU_ACCU_W-1:0]; // truncate tail accumulator

endmodule

`default_nettype wire

// ==== src/mvu_kernel.sv ====
// MVU kernel top: control pipeline, shared activation skews and one DSP chain per output lane
`timescale 1ns/1ps
`default_nettype none

`include "mvu_params.svh"

module mvu_kernel (
	input logic clk,
	input logic rst,
	input logic en_i, // accept a beat and advance, else hold
	input mvu_pkg::beat_t beat_i, // last and zero controls
	input mvu_pkg::actVec_t act_i, // activation vector, common to all lanes
	input mvu_pkg::wgtMat_t wgt_i, // one weight row per lane
	output logic vld_o, // p_o holds a finished dot product
	output mvu_pkg::accuVec_t p_o
);

	import mvu_pkg::*;

	segFlags_t zeroSeg;
	logic clearAcc;
	actSlice_t actSkewed [`MVU_CHAIN_LEN]; // per-slice activations after the skew
	accu_t laneP [`MVU_PE];

	mvu_control u_control (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.beat_i(beat_i),
		.zeroSeg_o(zeroSeg),
		.clearAcc_o(clearAcc),
		.vld_o(vld_o)
	);

	for (genvar j = 0; j < `MVU_CHAIN_LEN; j++) begin : genActSlice
		localparam int unsigned Lanes = sliceLanes(j);

		actSlice_t actIn; // zero-extended, unused lanes zero

		always_comb begin
			actIn = '0;
			for (int k = 0; k < Lanes; k++) begin
				actIn[k] = actLane_t'(act_i[`MVU_LANES * j + k]); // unsigned, so zero fill
			end
		end

		operand_skew #(
			.payload_t(actSlice_t),
			.Depth(skewDepth(j))
		) u_actSkew (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.d_i(actIn),
			.q_o(actSkewed[j])
		);
	end

	for (genvar i = 0; i < `MVU_PE; i++) begin : genLane
		pe_chain u_chain (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.actSlices_i(actSkewed),
			.wgt_i(wgt_i[i]),
			.zeroSeg_i(zeroSeg),
			.clearAcc_i(clearAcc),
			.p_o(laneP[i])
		);
	end

	always_comb begin
		for (int i = 0; i < `MVU_PE; i++) begin
			p_o[i] = laneP[i];
		end
	end

endmodule

`default_nettype wire

// ==== testbench/mvu_kernel_checker.sv ====
// MVU kernel protocol checker: reset, stall hold and vld causality, bound to the top level
`timescale 1ns/1ps
`default_nettype none

`include "mvu_params.svh"

module mvu_kernel_checker (
	input logic clk,
	input logic rst,
	input logic en_i,
	input mvu_pkg::beat_t beat_i,
	input logic vld_o,
	input mvu_pkg::accuVec_t p_o
);

	import mvu_pkg::*;

	// bit k set when a last beat was accepted k+1 enabled cycles ago
	logic [`MVU_LATENCY-1:0] lastSeen;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastSeen <= '0;
		end else if (en_i) begin
			lastSeen <= {lastSeen[`MVU_LATENCY-2:0], beat_i.last}; // age by one enabled cycle
		end
	end

	aVldReset: assert property (@(posedge clk) rst |=> !vld_o)
		else $error("vld_o high after a reset cycle");

	// stalled cycle must leave the outputs untouched
	aStallHold: assert property (@(posedge clk) disable iff (rst)
		!en_i |=> ($stable(vld_o) && $stable(p_o)))
		else $error("vld_o or p_o changed while en_i was low");

	aVldCause: assert property (@(posedge clk) disable iff (rst)
		$rose(vld_o) |-> lastSeen[`MVU_LATENCY-1])
		else $error("vld_o rose without a last beat at the pipeline latency");

endmodule

`default_nettype wire

// ==== testbench/mvu_kernel_tb.sv ====
// MVU kernel testbench: table-driven beats, reference dot products and per-cycle output compare
`timescale 1ns/1ps
`default_nettype none

`include "mvu_params.svh"

module mvu_kernel_tb;

	import mvu_pkg::*;

	typedef struct packed {
		logic en; // beat accepted
		logic last; // closes the dot product
		logic zero; // beat dropped
		logic [8:0] actSeed; // Rnd or a fill byte for all activations
		logic [8:0] wgtSeed; // Rnd or a fill byte for all weights
	} stim_t;

	localparam int NumStim = 26;
	localparam logic [8:0] Rnd = 9'h100; // draw operands from the lfsr
	localparam int TimeoutCycles = NumStim * 2 + `MVU_LATENCY + 20;
	localparam int MaxEdges = TimeoutCycles; // enabled edges never outnumber cycles
	localparam logic [31:0] LfsrTaps = 32'h8020_0003; // x^32+x^22+x^2+x+1

	logic clk;
	logic rst;
	logic en_i;
	beat_t beat_i;
	actVec_t act_i;
	wgtMat_t wgt_i;
	logic vld_o;
	accuVec_t p_o;

	stim_t stimTable [NumStim];
	logic [31:0] lfsr; // operand generator state
	int acc [`MVU_PE]; // reference accumulators
	accuVec_t expQ [$]; // finished reference results, oldest first
	accuVec_t curExp; // result expected on p_o while vld_o holds
	bit vldAt [MaxEdges]; // vld_o expected after enabled edge k
	int enEdges; // enabled edges so far
	int vldErrors;
	int accuErrors;
	int otherErrors;
	int cycleCount;

	mvu_kernel u_dut (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.beat_i(beat_i),
		.act_i(act_i),
		.wgt_i(wgt_i),
		.vld_o(vld_o),
		.p_o(p_o)
	);

	bind mvu_kernel mvu_kernel_checker u_checker (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.beat_i(beat_i),
		.vld_o(vld_o),
		.p_o(p_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk; // 10 ns period
		end
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic stim_t makeRow(input logic en, input logic last, input logic zero,
			input logic [8:0] actSeed, input logic [8:0] wgtSeed);
		stim_t r;
		r.en = en;
		r.last = last;
		r.zero = zero;
		r.actSeed = actSeed;
		r.wgtSeed = wgtSeed;
		return r;
	endfunction

	task automatic loadTable();
		stimTable[0] = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd); // first run of three beats
		stimTable[1] = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[2] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd);
		stimTable[3] = makeRow(1'b1, 1'b1, 1'b0, 9'h0FF, 9'h080); // max act, weight -128
		stimTable[4] = makeRow(1'b1, 1'b1, 1'b0, 9'h0FF, 9'h07F); // max act, weight +127
		stimTable[5] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd); // back-to-back singles
		stimTable[6] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd);
		stimTable[7] = makeRow(1'b1, 1'b0, 1'b1, 9'h0FF, 9'h07F); // zeroed, must vanish
		stimTable[8] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd);
		stimTable[9] = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[10] = makeRow(1'b1, 1'b1, 1'b1, Rnd, Rnd); // zero beat closing a run
		stimTable[11] = makeRow(1'b1, 1'b1, 1'b1, 9'h0FF, 9'h080); // lone zero beat gives 0
		stimTable[12] = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[13] = makeRow(1'b0, 1'b1, 1'b0, Rnd, Rnd); // stalled, last ignored
		stimTable[14] = makeRow(1'b0, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[15] = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[16] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd);
		stimTable[17] = makeRow(1'b0, 1'b0, 1'b0, Rnd, Rnd); // stall with results in flight
		stimTable[18] = makeRow(1'b0, 1'b1, 1'b1, Rnd, Rnd);
		stimTable[19] = makeRow(1'b0, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[20] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd);
		stimTable[21] = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd);
		stimTable[22] = makeRow(1'b0, 1'b0, 1'b0, Rnd, Rnd); // stall inside a run
		stimTable[23] = makeRow(1'b1, 1'b1, 1'b0, Rnd, Rnd);
		stimTable[24] = makeRow(1'b1, 1'b1, 1'b0, 9'h000, Rnd); // zero activations
		stimTable[25] = makeRow(1'b0, 1'b0, 1'b0, Rnd, Rnd);
	endtask

	task automatic makeOperands(input stim_t row, output actVec_t act, output wgtMat_t wgt);
		logic [31:0] bits;
		for (int k = 0; k < `MVU_SIMD; k++) begin
			if (row.actSeed[8]) begin
				drawBits(`MVU_ACT_W, bits);
				act[k] = bits[`MVU_ACT_W-1:0];
			end else begin
				act[k] = row.actSeed[7:0];
			end
		end
		for (int i = 0; i < `MVU_PE; i++) begin
			for (int k = 0; k < `MVU_SIMD; k++) begin
				if (row.wgtSeed[8]) begin
					drawBits(`MVU_WGT_W, bits);
					wgt[i][k] = bits[`MVU_WGT_W-1:0];
				end else begin
					wgt[i][k] = row.wgtSeed[7:0];
				end
			end
		end
	endtask

	// reference: signed weight times unsigned activation, summed until last
	task automatic modelBeat(input beat_t b, input actVec_t act, input wgtMat_t wgt);
		accuVec_t res;
		int w;
		int a;
		if (!b.zero) begin
			for (int i = 0; i < `MVU_PE; i++) begin
				for (int k = 0; k < `MVU_SIMD; k++) begin
					w = int'($signed(wgt[i][k]));
					a = int'(act[k]); // zero extended
					acc[i] = acc[i] + w * a;
				end
			end
		end
		if (b.last) begin
			for (int i = 0; i < `MVU_PE; i++) begin
				res[i] = accu_t'(acc[i]);
				acc[i] = 0; // next dot product starts empty
			end
			expQ.push_back(res);
			vldAt[enEdges + `MVU_LATENCY - 1] = 1'b1; // latency counted in enabled edges
		end
		enEdges++;
	endtask

	task automatic checkVld(input logic got, input logic exp);
		if (got !== exp) begin
			vldErrors++;
			$display("ERROR vld_o: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic checkAccu(input accuVec_t got, input accuVec_t exp);
		for (int i = 0; i < `MVU_PE; i++) begin
			if (got[i] !== exp[i]) begin
				accuErrors++;
				$display("ERROR p_o[%0d]: got %h expected %h at %0t", i, got[i], exp[i], $time);
			end
		end
	endtask

	task automatic checkOutputs(input logic edgeEn);
		logic expVld;
		expVld = (enEdges > 0) ? vldAt[enEdges - 1] : 1'b0; // holds across stalls
		checkVld(vld_o, expVld);
		if (expVld) begin
			if (edgeEn) begin
				if (expQ.size() == 0) begin
					otherErrors++;
					$display("a result slot was reached with no reference result queued");
				end else begin
					curExp = expQ.pop_front(); // new result this cycle
				end
			end
			checkAccu(p_o, curExp);
		end
	endtask

	// one clock: model what the DUT captured, drive the next beat, check at the falling edge
	task automatic stepCycle(input stim_t row);
		logic edgeEn;
		beat_t beat;
		actVec_t act;
		wgtMat_t wgt;
		@(posedge clk);
		edgeEn = en_i && !rst;
		if (edgeEn) begin
			modelBeat(beat_i, act_i, wgt_i); // inputs taken at this edge
		end
		makeOperands(row, act, wgt);
		beat.last = row.last;
		beat.zero = row.zero;
		en_i <= row.en;
		beat_i <= beat;
		act_i <= act;
		wgt_i <= wgt;
		@(negedge clk);
		checkOutputs(edgeEn);
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < TimeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the test did not finish within %0d cycles", TimeoutCycles);
		$display("Regression failed");
		$finish;
	end

	initial begin
		stim_t idle;
		rst = 1'b1;
		en_i = 1'b0;
		beat_i = '0;
		act_i = '0;
		wgt_i = '0;
		lfsr = 32'h8362;
		enEdges = 0;
		vldErrors = 0;
		accuErrors = 0;
		otherErrors = 0;
		curExp = '0;
		for (int i = 0; i < `MVU_PE; i++) begin
			acc[i] = 0;
		end
		for (int k = 0; k < MaxEdges; k++) begin
			vldAt[k] = 1'b0;
		end
		loadTable();
		idle = makeRow(1'b1, 1'b0, 1'b0, Rnd, Rnd); // enabled, no last
		for (int c = 0; c < 3; c++) begin
			@(posedge clk);
			if (c == 2) begin
				rst <= 1'b0; // three reset edges
			end
			@(negedge clk);
			checkVld(vld_o, 1'b0);
		end
		for (int r = 0; r < NumStim; r++) begin
			stepCycle(stimTable[r]);
		end
		while (expQ.size() > 0) begin
			stepCycle(idle); // drain results still in the pipe
		end
		stepCycle(idle); // vld_o drops after the last result
		$display("error count: vld_o %0d, p_o %0d, other %0d", vldErrors, accuErrors, otherErrors);
		if (vldErrors + accuErrors + otherErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
src/mvu_pkg.sv
src/operand_skew.sv
src/mvu_control.sv
src/dot_slice.sv
src/pe_chain.sv
src/mvu_kernel.sv
testbench/mvu_kernel_checker.sv
testbench/mvu_kernel_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the MVU kernel testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--timescale 1ns/1ps \
	--top-module mvu_kernel_tb \
	-f sources.f \
	--Mdir obj_dir \
	-o mvu_kernel_sim

./obj_dir/mvu_kernel_sim 2>&1 | tee sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
exit 1
